// File: rtl/clock_cfg.svh
`ifndef CLOCK_CFG_SVH
`define CLOCK_CFG_SVH

// tick divisors in clk cycles, 50 MHz board clock
`define CLK_SEC_DIV	50000000
`define CLK_SCAN_DIV	50000	// 1 kHz digit step

// ----------------------------------------------------------------------
// time field limits
// ----------------------------------------------------------------------
`define CLK_SEC_MAX	59
`define CLK_MIN_MAX	59
`define CLK_HR_MAX	23	// 24-hour format

// digits on the display
`define CLK_NUM_DIGITS	6

`endif

// File: rtl/clock_pkg.sv
package clock_pkg;

	// one hh, mm or ss field
	typedef logic [5:0] hms_t;

	// one-hot increment pulse, one bit per field
	typedef logic [2:0] field_sel_t;

	localparam int FS_SEC = 0;
	localparam int FS_MIN = 1;
	localparam int FS_HR  = 2;

	typedef enum logic [1:0] {
		MODE_CLOCK = 2'b00,
		MODE_SETUP = 2'b01,	// time stopped, fields stepped by hand
		MODE_ALARM = 2'b10	// alarm shown, clock keeps running
	} mode_e;

	typedef enum logic [1:0] {
		POS_SEC = 2'b00,
		POS_MIN = 2'b01,
		POS_HR  = 2'b10
	} pos_e;

endpackage

// File: rtl/seg_pkg.sv
package seg_pkg;

	// bcd digit 0..9
	typedef logic [3:0] digit_t;

	// {a, b, c, d, e, f, g}, active high
	typedef logic [6:0] seg_t;

	// one bit per digit, active low
	typedef logic [5:0] digit_en_t;

	// scan position 0..5
	typedef logic [2:0] digit_idx_t;

	localparam seg_t SEG_BLANK = 7'b000_0000;

endpackage

// File: rtl/tick_gen.sv
`timescale 1ns/10ps

`include "clock_cfg.svh"

module tick_gen #(
	parameter int SEC_DIV  = `CLK_SEC_DIV,
	parameter int SCAN_DIV = `CLK_SCAN_DIV
) (
	input  logic clk,
	input  logic rst_n,
	output logic o_sec_tick,
	output logic o_scan_tick
);

	localparam int NUM_TICKS = 2;	// 0: seconds, 1: scan

	// ----------------------------------------------------------------------
	// one down counter per tick, pulse on wrap
	// ----------------------------------------------------------------------
	for (genvar g = 0; g < NUM_TICKS; g++) begin : g_div
		localparam int DIV = (g == 0) ? SEC_DIV : SCAN_DIV;
		localparam int CW  = (DIV > 1) ? $clog2(DIV) : 1;
		localparam logic [CW-1:0] RELOAD = CW'(DIV - 1);

		logic [CW-1:0] cnt;
		logic          tick;

		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n) begin
				cnt  <= RELOAD;
				tick <= 1'b0;
			end else if (cnt == '0) begin
				cnt  <= RELOAD;
				tick <= 1'b1;	// first pulse DIV cycles after reset
			end else begin
				cnt  <= cnt - 1'b1;
				tick <= 1'b0;
			end
		end
	end

	assign o_sec_tick  = g_div[0].tick;
	assign o_scan_tick = g_div[1].tick;

endmodule

// File: rtl/clock_ctrl.sv
`timescale 1ns/10ps

module clock_ctrl
	import clock_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       i_btn_mode,
	input  logic       i_btn_pos,
	input  logic       i_btn_inc,
	input  logic       i_btn_alarm,
	output logic       o_run,
	output logic       o_show_alarm,
	output logic       o_alarm_en,
	output field_sel_t o_time_inc,
	output field_sel_t o_alarm_inc
);

	logic [3:0] btn_q;	// last sampled levels
	logic       mode_rise;
	logic       pos_rise;
	logic       inc_rise;
	logic       alarm_rise;

	mode_e      mode;
	pos_e       pos;
	logic       alarm_en;
	field_sel_t pos_sel;

	// ----------------------------------------------------------------------
	// button edges
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			btn_q <= '0;
		else
			btn_q <= {i_btn_alarm, i_btn_inc, i_btn_pos, i_btn_mode};
	end

	assign mode_rise  = i_btn_mode  & ~btn_q[0];
	assign pos_rise   = i_btn_pos   & ~btn_q[1];
	assign inc_rise   = i_btn_inc   & ~btn_q[2];
	assign alarm_rise = i_btn_alarm & ~btn_q[3];

	// ----------------------------------------------------------------------
	// mode, position and alarm enable
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mode     <= MODE_CLOCK;
			pos      <= POS_SEC;
			alarm_en <= 1'b0;
		end else begin
			if (mode_rise) begin
				case (mode)
					MODE_CLOCK: mode <= MODE_SETUP;
					MODE_SETUP: mode <= MODE_ALARM;
					default:    mode <= MODE_CLOCK;
				endcase
				pos <= POS_SEC;	// every mode starts on seconds
			end else if (pos_rise) begin
				case (pos)
					POS_SEC: pos <= POS_MIN;
					POS_MIN: pos <= POS_HR;
					default: pos <= POS_SEC;
				endcase
			end
			if (alarm_rise)
				alarm_en <= ~alarm_en;
		end
	end

	always_comb begin
		pos_sel = '0;
		case (pos)
			POS_MIN: pos_sel[FS_MIN] = 1'b1;
			POS_HR:  pos_sel[FS_HR]  = 1'b1;
			default: pos_sel[FS_SEC] = 1'b1;
		endcase
	end

	// inc goes to the time in setup, to the alarm in alarm mode
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_time_inc  <= '0;
			o_alarm_inc <= '0;
		end else begin
			o_time_inc  <= (inc_rise && mode == MODE_SETUP) ? pos_sel : '0;
			o_alarm_inc <= (inc_rise && mode == MODE_ALARM) ? pos_sel : '0;
		end
	end

	assign o_run        = (mode != MODE_SETUP);
	assign o_show_alarm = (mode == MODE_ALARM);
	assign o_alarm_en   = alarm_en;

endmodule

// File: rtl/time_keeper.sv
`timescale 1ns/10ps

`include "clock_cfg.svh"

module time_keeper
	import clock_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       i_sec_tick,
	input  logic       i_run,
	input  logic       i_show_alarm,
	input  logic       i_alarm_en,
	input  field_sel_t i_time_inc,
	input  field_sel_t i_alarm_inc,
	output hms_t       o_disp_sec,
	output hms_t       o_disp_min,
	output hms_t       o_disp_hr,
	output logic       o_alarm
);

	localparam hms_t SEC_LAST = hms_t'(`CLK_SEC_MAX);
	localparam hms_t MIN_LAST = hms_t'(`CLK_MIN_MAX);
	localparam hms_t HR_LAST  = hms_t'(`CLK_HR_MAX);

	hms_t sec;
	hms_t min;
	hms_t hr;
	hms_t al_sec;
	hms_t al_min;
	hms_t al_hr;

	logic advance;
	logic match;

	// wrap to zero after the last value
	function automatic hms_t step(input hms_t v, input hms_t last);
		return (v == last) ? '0 : v + 6'd1;
	endfunction

	assign advance = i_sec_tick & i_run;

	// ----------------------------------------------------------------------
	// time fields, carry only on the running tick
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sec <= '0;
			min <= '0;
			hr  <= '0;
		end else if (advance) begin
			sec <= step(sec, SEC_LAST);
			if (sec == SEC_LAST) begin
				min <= step(min, MIN_LAST);
				if (min == MIN_LAST)
					hr <= step(hr, HR_LAST);	// 23:59:59 -> 00:00:00
			end
		end else begin
			// setup stepping, no carry
			if (i_time_inc[FS_SEC])
				sec <= step(sec, SEC_LAST);
			if (i_time_inc[FS_MIN])
				min <= step(min, MIN_LAST);
			if (i_time_inc[FS_HR])
				hr <= step(hr, HR_LAST);
		end
	end

	// ----------------------------------------------------------------------
	// alarm fields
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			al_sec <= '0;
			al_min <= '0;
			al_hr  <= '0;
		end else begin
			if (i_alarm_inc[FS_SEC])
				al_sec <= step(al_sec, SEC_LAST);
			if (i_alarm_inc[FS_MIN])
				al_min <= step(al_min, MIN_LAST);
			if (i_alarm_inc[FS_HR])
				al_hr <= step(al_hr, HR_LAST);
		end
	end

	// display source follows the mode
	always_comb begin
		if (i_show_alarm) begin
			o_disp_sec = al_sec;
			o_disp_min = al_min;
			o_disp_hr  = al_hr;
		end else begin
			o_disp_sec = sec;
			o_disp_min = min;
			o_disp_hr  = hr;
		end
	end

	assign match = (sec == al_sec) && (min == al_min) && (hr == al_hr);

	// latched on match, held until alarm is disabled
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			o_alarm <= 1'b0;
		else
			o_alarm <= i_alarm_en & (o_alarm | match);
	end

endmodule

// File: rtl/seg_scan.sv
`timescale 1ns/10ps

`include "clock_cfg.svh"

module seg_scan
	import clock_pkg::*;
	import seg_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      i_scan_tick,
	input  hms_t      i_disp_sec,
	input  hms_t      i_disp_min,
	input  hms_t      i_disp_hr,
	output seg_t      o_seg,
	output digit_en_t o_seg_enb
);

	localparam digit_idx_t LAST_IDX = digit_idx_t'(`CLK_NUM_DIGITS - 1);

	digit_t     digits [`CLK_NUM_DIGITS];
	digit_idx_t idx;
	digit_idx_t idx_nxt;

	function automatic digit_t tens(input hms_t v);
		return digit_t'(v / 6'd10);
	endfunction

	function automatic digit_t units(input hms_t v);
		return digit_t'(v % 6'd10);
	endfunction

	function automatic seg_t decode(input digit_t d);
		case (d)
			4'd0:    return 7'b111_1110;
			4'd1:    return 7'b011_0000;
			4'd2:    return 7'b110_1101;
			4'd3:    return 7'b111_1001;
			4'd4:    return 7'b011_0011;
			4'd5:    return 7'b101_1011;
			4'd6:    return 7'b101_1111;
			4'd7:    return 7'b111_0000;
			4'd8:    return 7'b111_1111;
			4'd9:    return 7'b111_0011;
			default: return SEG_BLANK;
		endcase
	endfunction

	// ----------------------------------------------------------------------
	// digit order: hh mm ss, tens first
	// ----------------------------------------------------------------------
	always_comb begin
		digits[0] = tens(i_disp_hr);
		digits[1] = units(i_disp_hr);
		digits[2] = tens(i_disp_min);
		digits[3] = units(i_disp_min);
		digits[4] = tens(i_disp_sec);
		digits[5] = units(i_disp_sec);
	end

	assign idx_nxt = (idx == LAST_IDX) ? '0 : idx + 3'd1;

	// pattern and enable move together, one cycle after the tick
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			idx       <= '0;
			o_seg     <= decode(4'd0);
			o_seg_enb <= ~digit_en_t'(1);	// digit 0 lit
		end else if (i_scan_tick) begin
			idx       <= idx_nxt;
			o_seg     <= decode(digits[idx_nxt]);
			o_seg_enb <= ~(digit_en_t'(1) << idx_nxt);
		end
	end

endmodule

// File: rtl/digital_clock_top.sv
`timescale 1ns/10ps

`include "clock_cfg.svh"

module digital_clock_top
	import clock_pkg::*;
	import seg_pkg::*;
#(
	parameter int SEC_DIV  = `CLK_SEC_DIV,
	parameter int SCAN_DIV = `CLK_SCAN_DIV
) (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      i_btn_mode,
	input  logic      i_btn_pos,
	input  logic      i_btn_inc,
	input  logic      i_btn_alarm,
	output seg_t      o_seg,
	output digit_en_t o_seg_enb,
	output logic      o_alarm
);

	logic       sec_tick;
	logic       scan_tick;
	logic       run;
	logic       show_alarm;
	logic       alarm_en;
	field_sel_t time_inc;
	field_sel_t alarm_inc;
	hms_t       disp_sec;
	hms_t       disp_min;
	hms_t       disp_hr;

	tick_gen #(
		.SEC_DIV  (SEC_DIV),
		.SCAN_DIV (SCAN_DIV)
	) u_tick (
		.clk         (clk),
		.rst_n       (rst_n),
		.o_sec_tick  (sec_tick),
		.o_scan_tick (scan_tick)
	);

	clock_ctrl u_ctrl (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_btn_mode   (i_btn_mode),
		.i_btn_pos    (i_btn_pos),
		.i_btn_inc    (i_btn_inc),
		.i_btn_alarm  (i_btn_alarm),
		.o_run        (run),
		.o_show_alarm (show_alarm),
		.o_alarm_en   (alarm_en),
		.o_time_inc   (time_inc),
		.o_alarm_inc  (alarm_inc)
	);

	time_keeper u_keeper (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_sec_tick   (sec_tick),
		.i_run        (run),
		.i_show_alarm (show_alarm),
		.i_alarm_en   (alarm_en),
		.i_time_inc   (time_inc),
		.i_alarm_inc  (alarm_inc),
		.o_disp_sec   (disp_sec),
		.o_disp_min   (disp_min),
		.o_disp_hr    (disp_hr),
		.o_alarm      (o_alarm)
	);

	seg_scan u_scan (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_scan_tick (scan_tick),
		.i_disp_sec  (disp_sec),
		.i_disp_min  (disp_min),
		.i_disp_hr   (disp_hr),
		.o_seg       (o_seg),
		.o_seg_enb   (o_seg_enb)
	);

endmodule

// File: tb/clock_monitor.sv
`timescale 1ns/10ps

module clock_monitor
	import seg_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  seg_t        i_seg,
	input  digit_en_t   i_seg_enb,
	input  int          i_mode,	// 0 clock, 1 setup, 2 alarm
	input  int          i_pos,	// 0 sec, 1 min, 2 hr
	output logic [17:0] o_reading,	// {hr, min, sec}
	output int          o_count,
	output int          o_errors
);

	logic [3:0]  cur [6];
	logic [5:0]  seen;
	logic        published;
	logic [17:0] prev;
	logic        have_prev;
	int          prev_mode;
	int          skip_left;
	int          err;

	function automatic int seg_to_digit(input seg_t p);
		case (p)
			7'h7e:   return 0;
			7'h30:   return 1;
			7'h6d:   return 2;
			7'h79:   return 3;
			7'h33:   return 4;
			7'h5b:   return 5;
			7'h5f:   return 6;
			7'h70:   return 7;
			7'h7f:   return 8;
			7'h73:   return 9;
			default: return -1;
		endcase
	endfunction

	// seconds roll into minutes, minutes into hours, hours wrap after 23
	function automatic logic [17:0] next_second(input logic [17:0] t);
		int h;
		int m;
		int s;
		h = t[17:12];
		m = t[11:6];
		s = t[5:0];
		s++;
		if (s == 60) begin
			s = 0;
			m++;
			if (m == 60) begin
				m = 0;
				h = (h + 1) % 24;
			end
		end
		return {6'(h), 6'(m), 6'(s)};
	endfunction

	// one field only, no carry
	function automatic logic [17:0] step_field(input logic [17:0] t, input int pos);
		logic [17:0] r;
		r = t;
		case (pos)
			0:       r[5:0] = (t[5:0] == 6'd59) ? 6'd0 : t[5:0] + 6'd1;
			1:       r[11:6] = (t[11:6] == 6'd59) ? 6'd0 : t[11:6] + 6'd1;
			default: r[17:12] = (t[17:12] == 6'd23) ? 6'd0 : t[17:12] + 6'd1;
		endcase
		return r;
	endfunction

	function automatic string hms_str(input logic [17:0] t);
		return $sformatf("%02d:%02d:%02d", t[17:12], t[11:6], t[5:0]);
	endfunction

	task automatic compare(input string name, input logic [17:0] exp, input logic [17:0] act);
		if (exp !== act) begin
			err++;
			$display("Error %s: expected %s actual %s", name, hms_str(exp), hms_str(act));
		end
	endtask

	// ----------------------------------------------------------------------
	// capture one digit per cycle, publish a reading once a scan is clean
	// ----------------------------------------------------------------------
	always @(posedge clk or negedge rst_n) begin : capture
		int          idx;
		int          d;
		logic [17:0] t;
		if (!rst_n) begin
			for (int i = 0; i < 6; i++)
				cur[i] = 4'hf;
			seen = '0;
			published = 1'b0;
			have_prev = 1'b0;
			prev_mode = 0;
			skip_left = 0;
			err = 0;
			o_count <= 0;
			o_errors <= 0;
			o_reading <= '0;
		end else if ($countones(~i_seg_enb) == 1) begin
			idx = 0;
			for (int i = 0; i < 6; i++)
				if (!i_seg_enb[i])
					idx = i;
			d = seg_to_digit(i_seg);
			if (d < 0) begin
				err++;
				$display("Unknown segment pattern %b on digit %0d", i_seg, idx);
			end else if (d != cur[idx]) begin
				cur[idx] = 4'(d);
				seen = 6'(1 << idx);
				published = 1'b0;
			end else begin
				seen |= 6'(1 << idx);
			end
			if (seen == 6'h3f && !published) begin
				published = 1'b1;
				t = {6'(cur[0] * 10 + cur[1]), 6'(cur[2] * 10 + cur[3]),
					6'(cur[4] * 10 + cur[5])};
				// display source switched, clock mode may catch a tick mid-scan
				if (have_prev && i_mode != prev_mode && !(i_mode == 1 && prev_mode == 0))
					skip_left = (i_mode == 0) ? 2 : 1;
				if (!have_prev || skip_left > 0)
					skip_left = (skip_left > 0) ? skip_left - 1 : 0;
				else if (i_mode == 0)
					compare("count", next_second(prev), t);
				else if (i_mode == 1)
					compare("setup", step_field(prev, i_pos), t);
				else
					compare("alarm_set", step_field(prev, i_pos), t);
				prev = t;
				prev_mode = i_mode;
				have_prev = 1'b1;
				o_reading <= t;
				o_count <= o_count + 1;
			end
			o_errors <= err;
		end
	end

endmodule

// File: tb/clock_asserts.sv
`timescale 1ns/10ps

module clock_asserts
	import seg_pkg::*;
(
	input logic      clk,
	input logic      rst_n,
	input digit_en_t i_seg_enb,
	input logic      i_alarm,
	input logic      i_alarm_en
);

	int fails = 0;	// read by the testbench top

	// exactly one digit lit at any time
	a_one_low: assert property (@(posedge clk) disable iff (!rst_n)
		$countones(~i_seg_enb) == 1)
	else begin
		fails++;
		$error("digit enable does not have exactly one low bit: %b", i_seg_enb);
	end

	a_scan_step: assert property (@(posedge clk) disable iff (!rst_n)
		!$stable(i_seg_enb) |-> i_seg_enb == {$past(i_seg_enb[4:0]), $past(i_seg_enb[5])})
	else begin
		fails++;
		$error("digit enable skipped a scan position: %b", i_seg_enb);
	end

	// one cycle of latency allowed after disable
	a_alarm_off: assert property (@(posedge clk) disable iff (!rst_n)
		(!i_alarm_en && !$past(i_alarm_en)) |-> !i_alarm)
	else begin
		fails++;
		$error("alarm output high while alarm is disabled");
	end

endmodule

bind digital_clock_top clock_asserts u_asserts (
	.clk        (clk),
	.rst_n      (rst_n),
	.i_seg_enb  (o_seg_enb),
	.i_alarm    (o_alarm),
	.i_alarm_en (alarm_en)
);

// File: tb/clock_tb.sv
`timescale 1ns/10ps

module clock_tb;

	localparam int B_MODE = 0;
	localparam int B_POS = 1;
	localparam int B_INC = 2;
	localparam int B_ALARM = 3;
	localparam int RD_TIMEOUT = 120;	// cycles between stable readings

	logic        clk;
	logic        rst_n;
	logic [3:0]  btn;	// alarm, inc, pos, mode
	logic [6:0]  seg;
	logic [5:0]  seg_enb;
	logic        alarm;
	logic [17:0] reading;
	int          rd_count;
	int          mon_errors;
	int          tb_mode;
	int          tb_pos;
	logic        al_en;
	int          off_cnt;
	int          tb_errors;
	int          timeouts;
	logic [31:0] rnd;
	logic [17:0] saved;

	digital_clock_top #(.SEC_DIV(40), .SCAN_DIV(2)) dut (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_btn_mode  (btn[B_MODE]),
		.i_btn_pos   (btn[B_POS]),
		.i_btn_inc   (btn[B_INC]),
		.i_btn_alarm (btn[B_ALARM]),
		.o_seg       (seg),
		.o_seg_enb   (seg_enb),
		.o_alarm     (alarm)
	);

	clock_monitor u_monitor (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_seg     (seg),
		.i_seg_enb (seg_enb),
		.i_mode    (tb_mode),
		.i_pos     (tb_pos),
		.o_reading (reading),
		.o_count   (rd_count),
		.o_errors  (mon_errors)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic string hms_str(input logic [17:0] t);
		return $sformatf("%02d:%02d:%02d", t[17:12], t[11:6], t[5:0]);
	endfunction

	task automatic finish_run();
		$display("errors: checks %0d, monitor %0d, assertions %0d, timeouts %0d",
			tb_errors, mon_errors, dut.u_asserts.fails, timeouts);
		if (tb_errors + mon_errors + dut.u_asserts.fails + timeouts == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	endtask

	task automatic check_time(input string name, input logic [17:0] exp);
		if (reading !== exp) begin
			tb_errors++;
			$display("Error %s: expected %s actual %s", name, hms_str(exp), hms_str(reading));
		end
	endtask

	// hold a button for two cycles, track what it does
	task automatic press(input int b);
		@(posedge clk);
		btn[b] <= 1'b1;
		if (b == B_MODE) begin
			tb_mode <= (tb_mode + 1) % 3;
			tb_pos <= 0;
		end else if (b == B_POS) begin
			tb_pos <= (tb_pos + 1) % 3;
		end else if (b == B_ALARM) begin
			al_en <= ~al_en;
		end
		repeat (2) @(posedge clk);
		btn <= '0;
	endtask

	task automatic gap();
		rnd = xorshift(rnd);
		repeat (16 + rnd % 32) @(posedge clk);
	endtask

	task automatic wait_reading();
		int c0;
		int t;
		c0 = rd_count;
		t = 0;
		while (rd_count == c0) begin
			@(posedge clk);
			t++;
			if (t > RD_TIMEOUT) begin
				$display("Timeout: the display produced no new stable reading");
				timeouts++;
				finish_run();
			end
		end
	endtask

	task automatic inc_press();
		press(B_INC);
		wait_reading();
		gap();
	endtask

	task automatic set_pos(input int target);
		while (tb_pos != target) begin
			press(B_POS);
			gap();
		end
	endtask

	// alarm must drop within a few cycles of being disabled
	always @(posedge clk) begin
		off_cnt = al_en ? 0 : off_cnt + 1;
		if (rst_n && alarm && off_cnt > 3) begin
			tb_errors++;
			$display("Alarm output is high while the alarm is disabled");
		end
	end

	initial begin : stimulus
		int t;
		rst_n = 1'b0;
		btn = '0;
		tb_mode = 0;
		tb_pos = 0;
		al_en = 1'b0;
		off_cnt = 0;
		tb_errors = 0;
		timeouts = 0;
		rnd = 32'h22a9;
		repeat (10) @(posedge clk);
		if (seg_enb !== 6'b111110 || alarm !== 1'b0) begin
			tb_errors++;
			$display("Error reset: expected enb 111110 alarm 0 actual enb %b alarm %b",
				seg_enb, alarm);
		end
		rst_n <= 1'b1;
		wait_reading();
		check_time("reset", 18'd0);
		repeat (3) wait_reading();

		// ------------------------------------------------------------------
		// setup: random steps, then 23:59:40
		// ------------------------------------------------------------------
		press(B_MODE);
		gap();
		repeat (8) begin
			rnd = xorshift(rnd);
			set_pos(rnd % 3);
			inc_press();
		end
		set_pos(0);
		repeat ((40 - reading[5:0] + 60) % 60) inc_press();
		set_pos(1);
		repeat ((59 - reading[11:6] + 60) % 60) inc_press();
		set_pos(2);
		repeat ((23 - reading[17:12] + 24) % 24) inc_press();
		check_time("setup_target", {6'd23, 6'd59, 6'd40});
		saved = reading;

		// alarm 00:00:03, left disabled
		press(B_MODE);
		wait_reading();
		check_time("alarm_show", 18'd0);
		repeat (3) inc_press();
		check_time("alarm_step", 18'd3);
		press(B_MODE);
		wait_reading();
		if (reading == saved) begin
			tb_errors++;
			$display("Error alarm_run: expected later than %s actual %s",
				hms_str(saved), hms_str(reading));
		end
		t = 0;
		while (reading != 18'd5) begin
			wait_reading();
			t++;
			if (t > 40) begin
				$display("Timeout: the time never reached 00:00:05 after rollover");
				timeouts++;
				finish_run();
			end
		end

		// ------------------------------------------------------------------
		// alarm 00:01:03, enabled
		// ------------------------------------------------------------------
		press(B_MODE);
		gap();
		press(B_MODE);
		wait_reading();
		set_pos(1);
		inc_press();
		check_time("alarm_step", {6'd0, 6'd1, 6'd3});
		press(B_ALARM);
		gap();
		press(B_MODE);
		t = 0;
		while (!alarm) begin
			@(posedge clk);
			t++;
			if (t > 4000) begin
				$display("Timeout: the alarm output never rose");
				timeouts++;
				finish_run();
			end
		end
		wait_reading();
		check_time("alarm_time", {6'd0, 6'd1, 6'd3});
		repeat (2) wait_reading();
		if (alarm !== 1'b1) begin
			tb_errors++;
			$display("Error alarm_hold: expected 1 actual %b", alarm);
		end
		press(B_ALARM);
		t = 0;
		while (alarm) begin
			@(posedge clk);
			t++;
			if (t > 10) begin
				$display("Timeout: the alarm output did not clear after disable");
				timeouts++;
				finish_run();
			end
		end
		finish_run();
	end

endmodule

// File: build.f
+incdir+rtl
rtl/clock_pkg.sv
rtl/seg_pkg.sv
rtl/tick_gen.sv
rtl/clock_ctrl.sv
rtl/time_keeper.sv
rtl/seg_scan.sv
rtl/digital_clock_top.sv
tb/clock_monitor.sv
tb/clock_asserts.sv
tb/clock_tb.sv

// File: Bender.yml
package:
  name: digital_clock

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/clock_pkg.sv
      - rtl/seg_pkg.sv
      - rtl/tick_gen.sv
      - rtl/clock_ctrl.sv
      - rtl/time_keeper.sv
      - rtl/seg_scan.sv
      - rtl/digital_clock_top.sv
  - target: test
    files:
      - tb/clock_monitor.sv
      - tb/clock_asserts.sv
      - tb/clock_tb.sv
